//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_rv_core -f sources.f -o sim_tb_rv_core

out=$(./obj_dir/sim_tb_rv_core)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1

//--- sources.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/mem_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_bus_arbiter.sv
verilog/rv_core.sv
verif/tb_rv_core.sv

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
	import rv_pkg::*;
();
	localparam int PROG_LEN = 28;
	localparam int N_STORES = 10;
	localparam int TIMEOUT = 200;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;

	// Stores the program must produce, in order, worked out from the ISA rules.
	// x1=5, x2=12, so ADD=17, SUB=7, AND=4, OR=13, XOR=9, and the JAL link is 96+4.
	localparam word_t EXP_ADDR [N_STORES] = '{
		32'h80, 32'h84, 32'h88, 32'h8C, 32'h90, 32'h94, 32'h98, 32'h9C, 32'hA8, 32'hB0
	};
	localparam word_t EXP_DATA [N_STORES] = '{
		32'd17, 32'd7, 32'd4, 32'd13, 32'd9, 32'h1234_5000, 32'd0, 32'd17, 32'd12, 32'd100
	};

	logic        clock;
	logic        arst_n;
	logic        mem_req;
	logic        mem_we;
	word_t       mem_addr;
	word_t       mem_wdata;
	logic        mem_ack;
	word_t       mem_rdata;
	logic        halted;
	word_t       prog [PROG_LEN];
	word_t       mem [64];
	logic [15:0] lfsr_state;
	int          errors;
	int          failures;
	int          store_idx;
	int          n_trans;
	bit          stop;

	rv_core u_rv_core (
		.clock     (clock),
		.arst_n    (arst_n),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata),
		.halted    (halted)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
	endfunction

	function automatic word_t enc_i(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic word_t enc_s(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(int imm, int rs2, int rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t enc_u(int imm, int rd);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic word_t enc_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// Galois LFSR with the polynomial x^16+x^14+x^13+x^11+1. It steps once per bit taken.
	function int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#0.5;
	endtask

	task automatic check_addr(word_t got, word_t exp, int n);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: store %0d address %h, expected %h", $time, n, got, exp);
		end
	endtask

	task automatic check_word(word_t got, word_t exp, int n);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: store %0d data %h, expected %h", $time, n, got, exp);
		end
	endtask

	task automatic check_halt();
		if (halted !== 1'b1) begin
			errors++;
			$display("Error at %0t: halted is %b, expected 1", $time, halted);
		end
	endtask

	task automatic load_program();
		prog[0] = enc_i(5, 0, 3'b000, 1, OPC_IMM);
		prog[1] = enc_i(12, 0, 3'b000, 2, OPC_IMM);
		prog[2] = enc_r(7'b0000000, 3'b000, 3, 1, 2);
		prog[3] = enc_r(7'b0100000, 3'b000, 4, 2, 1);
		prog[4] = enc_r(7'b0000000, 3'b111, 5, 1, 2);
		prog[5] = enc_r(7'b0000000, 3'b110, 6, 1, 2);
		prog[6] = enc_r(7'b0000000, 3'b100, 7, 1, 2);
		prog[7] = enc_u(32'h12345, 8);
		prog[8] = enc_s(128, 3, 0);
		prog[9] = enc_s(132, 4, 0);
		prog[10] = enc_s(136, 5, 0);
		prog[11] = enc_s(140, 6, 0);
		prog[12] = enc_s(144, 7, 0);
		prog[13] = enc_s(148, 8, 0);
		prog[14] = enc_i(99, 1, 3'b000, 0, OPC_IMM);
		prog[15] = enc_s(152, 0, 0);
		prog[16] = enc_i(128, 0, 3'b010, 9, OPC_LOAD);
		prog[17] = enc_s(156, 9, 0);
		// Taken BEQ and taken BNE each skip one store, then a BEQ falls through.
		prog[18] = enc_b(8, 9, 3, 3'b000);
		prog[19] = enc_s(160, 1, 0);
		prog[20] = enc_b(8, 2, 1, 3'b001);
		prog[21] = enc_s(164, 1, 0);
		prog[22] = enc_b(8, 2, 1, 3'b000);
		prog[23] = enc_s(168, 2, 0);
		prog[24] = enc_j(8, 10);
		prog[25] = enc_s(172, 1, 0);
		prog[26] = enc_s(176, 10, 0);
		prog[27] = 32'h0010_0073;
		for (int i = 0; i < 64; i++) begin
			mem[i] = ~(32'(i) * 32'd4);
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			mem[i] = prog[i];
		end
	endtask

	// Answers one four-phase transaction, or reports that the core halted.
	task automatic serve_one(output bit done_flag);
		int cycles;
		int delay;
		logic [5:0] idx;
		done_flag = 1'b0;
		cycles = 0;
		while (!mem_req && !halted) begin
			next_cycle();
			cycles++;
			if (cycles > TIMEOUT) begin
				failures++;
				$display("Timeout: no memory request and no halt within %0d cycles", TIMEOUT);
				done_flag = 1'b1;
				return;
			end
		end
		if (halted) begin
			done_flag = 1'b1;
			return;
		end
		delay = rand_bits(2);
		repeat (delay) next_cycle();
		if (mem_addr >= 32'd256) begin
			failures++;
			$display("Memory access at %h lies outside the 64-word model", mem_addr);
		end
		idx = mem_addr[7:2];
		if (mem_we) begin
			if (store_idx >= N_STORES) begin
				failures++;
				$display("Unexpected extra store to %h", mem_addr);
			end else begin
				check_addr(mem_addr, EXP_ADDR[store_idx], store_idx);
				check_word(mem_wdata, EXP_DATA[store_idx], store_idx);
			end
			store_idx++;
			mem[idx] = mem_wdata;
		end else begin
			mem_rdata = mem[idx];
		end
		mem_ack = 1'b1;
		cycles = 0;
		while (mem_req) begin
			next_cycle();
			cycles++;
			if (cycles > TIMEOUT) begin
				failures++;
				$display("Timeout: request was not released within %0d cycles", TIMEOUT);
				done_flag = 1'b1;
				return;
			end
		end
		mem_ack = 1'b0;
	endtask

	initial begin
		arst_n = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		lfsr_state = 16'd51;
		errors = 0;
		failures = 0;
		store_idx = 0;
		n_trans = 0;
		stop = 1'b0;
		load_program();
		repeat (10) next_cycle();
		arst_n = 1'b1;

		while (!stop) begin
			serve_one(stop);
			n_trans++;
			if (!stop && (n_trans > TIMEOUT)) begin
				failures++;
				$display("Timeout: the core did not halt within %0d transactions", TIMEOUT);
				stop = 1'b1;
			end
		end

		if (failures == 0) begin
			if (store_idx != N_STORES) begin
				failures++;
				$display("Saw %0d stores, but %0d were expected", store_idx, N_STORES);
			end
			// The halted core must stay off the bus.
			for (int i = 0; i < 20; i++) begin
				next_cycle();
				if (mem_req) begin
					failures++;
					$display("Memory request seen after the core halted");
					break;
				end
			end
			// Halt is permanent, so halted is still high after the quiet window.
			check_halt();
		end

		$display("Checks done: %0d errors, %0d other failures", errors, failures);
		if ((errors == 0) && (failures == 0)) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// Four-phase req/ack memory port. The master holds req, we, addr and wdata
// stable until ack rises, then drops req; the slave then drops ack.
interface mem_if
	import rv_pkg::*;
();
	logic  req;
	logic  we;
	word_t addr;
	word_t wdata;
	logic  ack;
	word_t rdata;

	modport master (
		output req, we, addr, wdata,
		input  ack, rdata
	);

	modport slave (
		input  req, we, addr, wdata,
		output ack, rdata
	);
endinterface

`default_nettype wire

//--- verilog/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
	import rv_pkg::*;
(
	input  op_kind_t op,
	input  word_t    src1,
	input  word_t    src2,
	input  word_t    imm,
	input  word_t    pc,
	output word_t    result,
	output word_t    next_pc
);
	logic taken;

	always_comb begin
		case (op)
			OP_ADD:  result = src1 + src2;
			OP_SUB:  result = src1 - src2;
			OP_AND:  result = src1 & src2;
			OP_OR:   result = src1 | src2;
			OP_XOR:  result = src1 ^ src2;
			OP_ADDI: result = src1 + imm;
			OP_LUI:  result = imm;
			// Effective address for memory operations.
			OP_LW:   result = src1 + imm;
			OP_SW:   result = src1 + imm;
			OP_JAL:  result = pc + 32'd4;
			default: result = '0;
		endcase
	end

	assign taken = (op == OP_JAL) ||
		((op == OP_BEQ) && (src1 == src2)) ||
		((op == OP_BNE) && (src1 != src2));

	assign next_pc = taken ? pc + imm : pc + 32'd4;

endmodule

`default_nettype wire

//--- verilog/rv_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bus_arbiter
	import rv_pkg::*;
(
	input  logic  clock,
	input  logic  arst_n,
	mem_if.slave  fetch_bus,
	mem_if.slave  data_bus,
	output logic  mem_req,
	output logic  mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input  logic  mem_ack,
	input  word_t mem_rdata
);
	logic locked;
	logic grant_data;
	logic sel_data;
	logic granted_req;

	// Data wins when idle; once locked the grant holds until the handshake ends.
	assign sel_data = locked ? grant_data : data_bus.req;
	assign granted_req = sel_data ? data_bus.req : fetch_bus.req;

	assign mem_req = granted_req;
	assign mem_we = sel_data ? data_bus.we : fetch_bus.we;
	assign mem_addr = sel_data ? data_bus.addr : fetch_bus.addr;
	assign mem_wdata = sel_data ? data_bus.wdata : fetch_bus.wdata;

	assign data_bus.ack = sel_data && mem_ack;
	assign data_bus.rdata = sel_data ? mem_rdata : '0;
	assign fetch_bus.ack = !sel_data && mem_ack;
	assign fetch_bus.rdata = sel_data ? '0 : mem_rdata;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			locked <= 1'b0;
			grant_data <= 1'b0;
		end else if (!locked) begin
			if (fetch_bus.req || data_bus.req) begin
				locked <= 1'b1;
				grant_data <= data_bus.req;
			end
		end else if (!granted_req && !mem_ack) begin
			locked <= 1'b0;
		end
	end

	// The sequencer keeps the two handshakes apart, so only one master ever requests.
	one_req_a: assert property (@(posedge clock) disable iff (!arst_n)
		!(fetch_bus.req && data_bus.req));

endmodule

`default_nettype wire

//--- verilog/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Address of the first instruction fetched after reset.
`define RV_RESET_PC 32'h0000_0000

// Width of data words, addresses and instructions.
`define RV_XLEN 32

// RV32E has sixteen integer registers.
`define RV_NREGS 16

`endif

//--- verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
	import rv_pkg::*;
(
	input  logic  clock,
	input  logic  arst_n,
	output logic  mem_req,
	output logic  mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input  logic  mem_ack,
	input  word_t mem_rdata,
	output logic  halted
);
	word_t    inst;
	word_t    pc;
	word_t    next_pc;
	word_t    imm;
	word_t    src1;
	word_t    src2;
	word_t    result;
	word_t    wb_data;
	op_kind_t op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic     reg_we;
	logic     lsu_start;
	logic     lsu_done;
	logic     retire;

	mem_if fetch_bus ();
	mem_if data_bus ();

	rv_fetch u_fetch (
		.clock     (clock),
		.arst_n    (arst_n),
		.bus       (fetch_bus.master),
		.next_pc   (next_pc),
		.op        (op),
		.lsu_done  (lsu_done),
		.inst      (inst),
		.pc        (pc),
		.lsu_start (lsu_start),
		.retire    (retire),
		.halted    (halted)
	);

	rv_decode u_decode (
		.inst   (inst),
		.op     (op),
		.rd     (rd),
		.rs1    (rs1),
		.rs2    (rs2),
		.imm    (imm),
		.reg_we (reg_we)
	);

	rv_alu u_alu (
		.op      (op),
		.src1    (src1),
		.src2    (src2),
		.imm     (imm),
		.pc      (pc),
		.result  (result),
		.next_pc (next_pc)
	);

	rv_regfile u_regfile (
		.clock  (clock),
		.arst_n (arst_n),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (src1),
		.rdata2 (src2),
		.waddr  (rd),
		.wdata  (wb_data),
		.wen    (reg_we),
		.retire (retire)
	);

	rv_lsu u_lsu (
		.clock      (clock),
		.arst_n     (arst_n),
		.bus        (data_bus.master),
		.start      (lsu_start),
		.op         (op),
		.addr       (result),
		.store_data (src2),
		.alu_result (result),
		.done       (lsu_done),
		.wb_data    (wb_data)
	);

	rv_bus_arbiter u_bus_arbiter (
		.clock     (clock),
		.arst_n    (arst_n),
		.fetch_bus (fetch_bus.slave),
		.data_bus  (data_bus.slave),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_ack   (mem_ack),
		.mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- verilog/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode
	import rv_pkg::*;
(
	input  word_t    inst,
	output op_kind_t op,
	output reg_idx_t rd,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output word_t    imm,
	output logic     reg_we
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       use_rs1;
	logic       use_rs2;
	logic       use_rd;
	logic       bad_reg;
	op_kind_t   base_op;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	// Only the low four bits of each register field exist in RV32E.
	assign rd = inst[10:7];
	assign rs1 = inst[18:15];
	assign rs2 = inst[23:20];

	always_comb begin
		base_op = OP_ILLEGAL;
		imm = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		use_rd = 1'b0;
		case (opcode)
			7'b0110011: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				use_rd = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: base_op = OP_ADD;
					10'b0100000_000: base_op = OP_SUB;
					10'b0000000_111: base_op = OP_AND;
					10'b0000000_110: base_op = OP_OR;
					10'b0000000_100: base_op = OP_XOR;
					default: base_op = OP_ILLEGAL;
				endcase
			end
			7'b0010011: begin
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				imm = {{20{inst[31]}}, inst[31:20]};
				if (funct3 == 3'b000) begin
					base_op = OP_ADDI;
				end
			end
			7'b0110111: begin
				use_rd = 1'b1;
				imm = {inst[31:12], 12'b0};
				base_op = OP_LUI;
			end
			7'b0000011: begin
				use_rs1 = 1'b1;
				use_rd = 1'b1;
				imm = {{20{inst[31]}}, inst[31:20]};
				if (funct3 == 3'b010) begin
					base_op = OP_LW;
				end
			end
			7'b0100011: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				if (funct3 == 3'b010) begin
					base_op = OP_SW;
				end
			end
			7'b1100011: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				if (funct3 == 3'b000) begin
					base_op = OP_BEQ;
				end else if (funct3 == 3'b001) begin
					base_op = OP_BNE;
				end
			end
			7'b1101111: begin
				use_rd = 1'b1;
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				base_op = OP_JAL;
			end
			7'b1110011: begin
				if (inst == 32'h0010_0073) begin
					base_op = OP_HALT;
				end
			end
			default: base_op = OP_ILLEGAL;
		endcase
	end

	// x16 to x31 do not exist, so naming one makes the instruction illegal.
	assign bad_reg = (use_rs1 && inst[19]) || (use_rs2 && inst[24]) || (use_rd && inst[11]);
	assign op = bad_reg ? OP_ILLEGAL : base_op;
	assign reg_we = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_ADDI, OP_LUI, OP_LW, OP_JAL};

endmodule

`default_nettype wire

//--- verilog/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module rv_fetch
	import rv_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	mem_if.master    bus,
	input  word_t    next_pc,
	input  op_kind_t op,
	input  logic     lsu_done,
	output word_t    inst,
	output word_t    pc,
	output logic     lsu_start,
	output logic     retire,
	output logic     halted
);
	fetch_state_t state;
	logic         req;
	logic         is_mem;
	logic         stop;

	assign is_mem = (op == OP_LW) || (op == OP_SW);
	assign stop = (op == OP_HALT) || (op == OP_ILLEGAL);

	assign retire = ((state == S_EXEC) && !is_mem && !stop) || ((state == S_MEM) && lsu_done);
	assign lsu_start = (state == S_EXEC) && is_mem;
	assign halted = (state == S_HALT);

	// Fetch only ever reads.
	assign bus.req = req;
	assign bus.we = 1'b0;
	assign bus.addr = pc;
	assign bus.wdata = '0;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_REQ;
			req <= 1'b0;
			pc <= `RV_RESET_PC;
		end else begin
			case (state)
				S_REQ: begin
					// The request is normally raised on retire; this covers the first fetch.
					if (!req) begin
						req <= 1'b1;
					end else if (bus.ack) begin
						req <= 1'b0;
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!bus.ack) begin
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					if (stop) begin
						state <= S_HALT;
					end else if (is_mem) begin
						state <= S_MEM;
					end
				end
				S_MEM: ;
				S_HALT: ;
				default: state <= S_HALT;
			endcase

			// Retiring from S_EXEC or S_MEM starts the next fetch right away.
			if (retire) begin
				pc <= next_pc;
				req <= 1'b1;
				state <= S_REQ;
			end
		end
	end

	always_ff @(posedge clock) begin
		if ((state == S_REQ) && req && bus.ack) begin
			inst <= bus.rdata;
		end
	end

	addr_stable_a: assert property (@(posedge clock) disable iff (!arst_n)
		bus.req && !bus.ack |=> $stable(bus.addr));

endmodule

`default_nettype wire

//--- verilog/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
	import rv_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	mem_if.master    bus,
	input  logic     start,
	input  op_kind_t op,
	input  word_t    addr,
	input  word_t    store_data,
	input  word_t    alu_result,
	output logic     done,
	output word_t    wb_data
);
	lsu_state_t state;
	logic       req;
	logic       we;
	word_t      addr_q;
	word_t      wdata_q;
	word_t      load_q;

	assign bus.req = req;
	assign bus.we = we;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;

	assign wb_data = (op == OP_LW) ? load_q : alu_result;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= L_IDLE;
			req <= 1'b0;
			we <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				L_IDLE: begin
					if (start) begin
						req <= 1'b1;
						we <= (op == OP_SW);
						state <= L_REQ;
					end
				end
				L_REQ: begin
					if (bus.ack) begin
						req <= 1'b0;
						state <= L_RELEASE;
					end
				end
				L_RELEASE: begin
					if (!bus.ack) begin
						done <= 1'b1;
						state <= L_IDLE;
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == L_IDLE) && start) begin
			addr_q <= addr;
			wdata_q <= store_data;
		end
		if ((state == L_REQ) && bus.ack) begin
			load_q <= bus.rdata;
		end
	end

	// The fetch sequencer must wait for done before it can start another access.
	start_idle_a: assert property (@(posedge clock) disable iff (!arst_n)
		start |-> state == L_IDLE);

endmodule

`default_nettype wire

//--- verilog/rv_pkg.sv
`default_nettype none
`include "rv_cfg.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

	// Decoded operation. Anything outside the supported subset is OP_ILLEGAL.
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_ADDI,
		OP_LUI,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_BNE,
		OP_JAL,
		OP_HALT,
		OP_ILLEGAL
	} op_kind_t;

	typedef enum logic [2:0] {
		S_REQ,
		S_RELEASE,
		S_EXEC,
		S_MEM,
		S_HALT
	} fetch_state_t;

	typedef enum logic [1:0] {
		L_IDLE,
		L_REQ,
		L_RELEASE
	} lsu_state_t;

endpackage

`default_nettype wire

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module rv_regfile
	import rv_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2,
	input  reg_idx_t waddr,
	input  word_t    wdata,
	input  logic     wen,
	input  logic     retire
);
	word_t regs [`RV_NREGS];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && retire && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire
